// ==== src/ppu_pkg.sv ====
package ppu_pkg;

    // dot position within a line or line within a frame
    typedef logic [8:0] dot_t;

    // {palette select, pixel value}
    typedef logic [3:0] color_idx_t;

    typedef logic [4:0] pal_addr_t;
    typedef logic [7:0] pal_entry_t;
    typedef logic [5:0] pixel_t;
    typedef logic [7:0] line_idx_t;

    // frame geometry of 341 dots by 262 lines
    localparam dot_t LAST_DOT  = 9'd340;
    localparam dot_t LAST_LINE = 9'd261;

    localparam int SCREEN_WIDTH = 256;

    // last dot of pixel output and sprite-zero checking
    localparam dot_t RENDER_END_DOT = 9'd255;
    localparam dot_t SP_FETCH_END   = 9'd320;
    localparam dot_t TILE_FETCH_END = 9'd336;

    localparam dot_t VIS_LAST_LINE = 9'd240;
    localparam dot_t POST_LINE     = 9'd241;

    // columns below this one can be clipped
    localparam dot_t LEFT_CLIP = 9'd8;

    // NMI pulse length in dots
    localparam dot_t NMI_DOTS = 9'd3;

    localparam pal_entry_t GREY_MASK = 8'h30;

    // horizontal phase within a scanline
    typedef enum logic [2:0] {
        SL_PRE_CYC,
        IDLE_CYC,
        SP_PRE_CYC,
        TL_PRE_CYC,
        GARB_CYC
    } hs_state_t;

    // vertical phase within a frame
    typedef enum logic [1:0] {
        PRE_SL,
        VIS_SL,
        POST_SL,
        VBLANK_SL
    } vs_state_t;

endpackage

// ==== src/ppu_timing_if.sv ====
interface ppu_timing_if import ppu_pkg::*; ();

    // current dot position
    dot_t col;
    dot_t row;

    // high on the last dot of every line
    logic line_end;

    hs_state_t hs_state;
    vs_state_t vs_state;

    modport counter (
        output col, row, line_end
    );

    modport fsm (
        input  col, row, line_end,
        output hs_state, vs_state
    );

    modport sink (
        input col, row, line_end, hs_state, vs_state
    );

endinterface

// ==== src/dot_counter.sv ====
module dot_counter import ppu_pkg::*; (
    input logic          clk,
    input logic          rst_n,
    input logic          dot_en,
    ppu_timing_if.counter tim
);

    assign tim.line_end = (tim.col == LAST_DOT);

    // column wraps at the last dot
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tim.col <= '0;
        end else if (dot_en) begin
            if (tim.line_end) begin
                tim.col <= '0;
            end else begin
                tim.col <= tim.col + 9'd1;
            end
        end
    end

    // row steps once per line and wraps after the last line
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tim.row <= '0;
        end else if (dot_en && tim.line_end) begin
            if (tim.row == LAST_LINE) begin
                tim.row <= '0;
            end else begin
                tim.row <= tim.row + 9'd1;
            end
        end
    end

endmodule

// ==== src/scan_fsm.sv ====
module scan_fsm import ppu_pkg::*; (
    input logic       clk,
    input logic       rst_n,
    input logic       dot_en,
    ppu_timing_if.fsm tim
);

    hs_state_t hs_next;
    vs_state_t vs_next;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tim.hs_state <= SL_PRE_CYC;
            tim.vs_state <= PRE_SL;
        end else if (dot_en) begin
            tim.hs_state <= hs_next;
            tim.vs_state <= vs_next;
        end
    end

    // next state is decided on the last col of each phase
    always_comb begin
        case (tim.hs_state)
            SL_PRE_CYC: begin
                hs_next = (tim.col < RENDER_END_DOT) ? SL_PRE_CYC : IDLE_CYC;
            end
            IDLE_CYC: begin
                hs_next = SP_PRE_CYC;
            end
            SP_PRE_CYC: begin
                hs_next = (tim.col < SP_FETCH_END) ? SP_PRE_CYC : TL_PRE_CYC;
            end
            TL_PRE_CYC: begin
                hs_next = (tim.col < TILE_FETCH_END) ? TL_PRE_CYC : GARB_CYC;
            end
            GARB_CYC: begin
                hs_next = tim.line_end ? SL_PRE_CYC : GARB_CYC;
            end
            default: begin
                hs_next = SL_PRE_CYC;
            end
        endcase
    end

    // frame phases change only at line end
    always_comb begin
        vs_next = tim.vs_state;
        if (tim.line_end) begin
            case (tim.vs_state)
                PRE_SL: begin
                    if (tim.row == '0) begin
                        vs_next = VIS_SL;
                    end
                end
                VIS_SL: begin
                    if (tim.row == VIS_LAST_LINE) begin
                        vs_next = POST_SL;
                    end
                end
                POST_SL: begin
                    if (tim.row == POST_LINE) begin
                        vs_next = VBLANK_SL;
                    end
                end
                VBLANK_SL: begin
                    if (tim.row == LAST_LINE) begin
                        vs_next = PRE_SL;
                    end
                end
                default: begin
                    vs_next = PRE_SL;
                end
            endcase
        end
    end

endmodule

// ==== src/pixel_compositor.sv ====
module pixel_compositor import ppu_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  dot_t       col,
    input  color_idx_t bg_idx,
    input  color_idx_t sp_idx,
    input  logic       sp_prio,
    input  logic       sp_zero,
    input  logic       show_bg,
    input  logic       show_sp,
    input  logic       show_bg_left,
    input  logic       show_sp_left,
    input  logic       greyscale,
    input  logic       pal_we,
    input  pal_addr_t  pal_addr,
    input  pal_entry_t pal_data,
    output pixel_t     pixel,
    output logic       opaque_overlap
);

    pal_entry_t pal_ram [32];

    color_idx_t bg_masked;
    color_idx_t sp_masked;
    logic       bg_opaque;
    logic       sp_opaque;
    pal_addr_t  merge_addr;
    pal_addr_t  ram_addr;
    pal_entry_t entry;
    pal_entry_t entry_grey;

    // show bits and left column clip
    assign bg_masked = (!show_bg || (col < LEFT_CLIP && !show_bg_left)) ? '0 : bg_idx;
    assign sp_masked = (!show_sp || (col < LEFT_CLIP && !show_sp_left)) ? '0 : sp_idx;

    // pixel value 0 is transparent
    assign bg_opaque = (bg_masked[1:0] != 2'd0);
    assign sp_opaque = (sp_masked[1:0] != 2'd0);

    // sprite palettes sit in the upper half of the RAM
    always_comb begin
        if (sp_opaque && (!bg_opaque || !sp_prio)) begin
            merge_addr = {1'b1, sp_masked};
        end else begin
            merge_addr = {1'b0, bg_masked};
        end
    end

    assign ram_addr = pal_we ? pal_addr : merge_addr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                pal_ram[i] <= '0;
            end
        end else if (pal_we) begin
            pal_ram[ram_addr] <= pal_data;
        end
    end

    assign entry      = pal_ram[ram_addr];
    assign entry_grey = greyscale ? (entry & GREY_MASK) : entry;
    assign pixel      = entry_grey[5:0];

    assign opaque_overlap = sp_zero && bg_opaque && sp_opaque;

endmodule

// ==== src/line_buffers.sv ====
module line_buffers import ppu_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        dot_en,
    ppu_timing_if.sink  tim,
    input  pixel_t      pixel,
    input  line_idx_t   disp_idx,
    output pixel_t      disp_pixel
);

    // line being drawn and line being shown
    pixel_t render_line [SCREEN_WIDTH];
    pixel_t disp_line   [SCREEN_WIDTH];

    line_idx_t wr_idx;
    logic      render_wr;

    // only during the visible output window
    assign render_wr = dot_en && (tim.vs_state == VIS_SL) && (tim.hs_state == SL_PRE_CYC);

    // 256 writes per line so the index wraps back to 0 by itself
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_idx <= '0;
            for (int i = 0; i < SCREEN_WIDTH; i++) begin
                render_line[i] <= '0;
            end
        end else if (render_wr) begin
            render_line[wr_idx] <= pixel;
            wr_idx <= wr_idx + 8'd1;
        end
    end

    // whole line copied on the last dot, shown during the next line
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < SCREEN_WIDTH; i++) begin
                disp_line[i] <= '0;
            end
        end else if (dot_en && tim.line_end) begin
            for (int i = 0; i < SCREEN_WIDTH; i++) begin
                disp_line[i] <= render_line[i];
            end
        end
    end

    assign disp_pixel = disp_line[disp_idx];

endmodule

// ==== src/ppu_status.sv ====
module ppu_status import ppu_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       dot_en,
    ppu_timing_if.sink tim,
    input  logic       opaque_overlap,
    input  logic       nmi_enable,
    output logic       vblank,
    output logic       sp_zero_hit,
    output logic       nmi_n
);

    logic frame_start;
    logic vblank_start;
    logic sp_zero_set;

    // first dot of the pre-render and post-render lines
    assign frame_start  = (tim.vs_state == PRE_SL) && (tim.col == '0);
    assign vblank_start = (tim.vs_state == POST_SL) && (tim.col == '0);

    assign sp_zero_set = opaque_overlap && (tim.vs_state == VIS_SL) &&
                         (tim.col <= RENDER_END_DOT);

    // active-low pulse over the first dots of the post-render line
    assign nmi_n = !(nmi_enable && (tim.vs_state == POST_SL) && (tim.col < NMI_DOTS));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vblank      <= 1'b0;
            sp_zero_hit <= 1'b0;
        end else if (dot_en) begin
            if (frame_start) begin
                vblank      <= 1'b0;
                sp_zero_hit <= 1'b0;
            end else begin
                if (vblank_start) begin
                    vblank <= 1'b1;
                end
                // sticky until the next frame
                if (sp_zero_set) begin
                    sp_zero_hit <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== src/ppu_core.sv ====
module ppu_core import ppu_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       dot_en,
    input  color_idx_t bg_idx,
    input  color_idx_t sp_idx,
    input  logic       sp_prio,
    input  logic       sp_zero,
    input  logic       show_bg,
    input  logic       show_sp,
    input  logic       show_bg_left,
    input  logic       show_sp_left,
    input  logic       greyscale,
    input  logic       nmi_enable,
    input  logic       pal_we,
    input  pal_addr_t  pal_addr,
    input  pal_entry_t pal_data,
    input  line_idx_t  disp_idx,
    output pixel_t     disp_pixel,
    output logic       vblank,
    output logic       sp_zero_hit,
    output logic       nmi_n
);

    pixel_t pixel;
    logic   opaque_overlap;

    ppu_timing_if tim ();

    dot_counter dot_counter_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .dot_en (dot_en),
        .tim    (tim.counter)
    );

    scan_fsm scan_fsm_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .dot_en (dot_en),
        .tim    (tim.fsm)
    );

    pixel_compositor pixel_compositor_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .col            (tim.col),
        .bg_idx         (bg_idx),
        .sp_idx         (sp_idx),
        .sp_prio        (sp_prio),
        .sp_zero        (sp_zero),
        .show_bg        (show_bg),
        .show_sp        (show_sp),
        .show_bg_left   (show_bg_left),
        .show_sp_left   (show_sp_left),
        .greyscale      (greyscale),
        .pal_we         (pal_we),
        .pal_addr       (pal_addr),
        .pal_data       (pal_data),
        .pixel          (pixel),
        .opaque_overlap (opaque_overlap)
    );

    line_buffers line_buffers_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .dot_en     (dot_en),
        .tim        (tim.sink),
        .pixel      (pixel),
        .disp_idx   (disp_idx),
        .disp_pixel (disp_pixel)
    );

    ppu_status ppu_status_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .dot_en         (dot_en),
        .tim            (tim.sink),
        .opaque_overlap (opaque_overlap),
        .nmi_enable     (nmi_enable),
        .vblank         (vblank),
        .sp_zero_hit    (sp_zero_hit),
        .nmi_n          (nmi_n)
    );

endmodule

// ==== tb/ppu_core_asserts.sv ====
module ppu_core_asserts import ppu_pkg::*; (
    input logic clk,
    input logic rst_n,
    input logic nmi_enable,
    input logic vblank,
    input logic sp_zero_hit,
    input logic nmi_n
);

    int fail_count = 0;
    int nmi_low;

    // length of the current nmi_n low pulse so far
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            nmi_low <= 0;
        end else if (!nmi_n) begin
            nmi_low <= nmi_low + 1;
        end else begin
            nmi_low <= 0;
        end
    end

    nmi_needs_enable: assert property (@(posedge clk) disable iff (!rst_n)
        !nmi_n |-> nmi_enable)
        else begin
            $error("nmi_n low while nmi_enable is low");
            fail_count++;
        end

    // vblank is registered one dot after the pulse starts
    nmi_needs_vblank: assert property (@(posedge clk) disable iff (!rst_n)
        !nmi_n |=> vblank)
        else begin
            $error("nmi_n low without vblank set");
            fail_count++;
        end

    nmi_pulse_length: assert property (@(posedge clk) disable iff (!rst_n)
        !nmi_n |-> nmi_low < int'(NMI_DOTS))
        else begin
            $error("nmi_n held low longer than the pulse length");
            fail_count++;
        end

    flags_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !vblank && !sp_zero_hit)
        else begin
            $error("status flags not clear after reset");
            fail_count++;
        end

    // the hit flag only clears at the start of a frame
    hit_clears_with_vblank: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(sp_zero_hit) |-> $fell(vblank))
        else begin
            $error("sp_zero_hit fell without vblank falling");
            fail_count++;
        end

endmodule

bind ppu_core ppu_core_asserts ppu_core_asserts_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .nmi_enable  (nmi_enable),
    .vblank      (vblank),
    .sp_zero_hit (sp_zero_hit),
    .nmi_n       (nmi_n)
);

// ==== tb/tb_ppu_core.sv ====
module tb_ppu_core import ppu_pkg::*; ();

    localparam int WAIT_LIMIT = 100000;

    logic       clk;
    logic       rst_n;
    logic       dot_en;
    color_idx_t bg_idx, sp_idx;
    logic       sp_prio, sp_zero;
    logic       show_bg, show_sp, show_bg_left, show_sp_left;
    logic       greyscale, nmi_enable, pal_we;
    pal_addr_t  pal_addr;
    pal_entry_t pal_data;
    line_idx_t  disp_idx;
    pixel_t     disp_pixel;
    logic       vblank, sp_zero_hit, nmi_n;

    // dot position tracked apart from the DUT
    int tb_row, tb_col;
    int seed, tests, failed, errors, test_errors, timeouts, assert_fails;
    color_idx_t const_bg;
    pal_entry_t pal_shadow [32];
    pixel_t     exp_line [256];

    ppu_core ppu_core_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tb_row <= 0;
            tb_col <= 0;
        end else if (dot_en) begin
            tb_col <= (tb_col == 340) ? 0 : tb_col + 1;
            if (tb_col == 340) begin
                tb_row <= (tb_row == 261) ? 0 : tb_row + 1;
            end
        end
    end

    task automatic check_value(input string name, input string what,
                               input int exp, input int act);
        assert (act == exp) else begin
            $display("FAIL %s %s expected %0d actual %0d", name, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (test_errors == 0) begin
            $display("[%s] passed", name);
        end else begin
            $display("[%s] failed with %0d errors", name, test_errors);
            failed++;
        end
        errors += test_errors;
        test_errors = 0;
    endtask

    // returns at the falling edge inside the given dot
    task automatic wait_dot(input int row, input int col);
        int n;
        n = 0;
        if (timeouts == 0) begin
            do begin
                @(negedge clk);
                n++;
            end while ((tb_row != row || tb_col != col) && n < WAIT_LIMIT);
            if (tb_row != row || tb_col != col) begin
                $display("timed out waiting for row %0d col %0d", row, col);
                timeouts++;
            end
        end
    endtask

    // clip, show bits, priority merge and greyscale on the shadow palette
    function automatic pixel_t expect_pixel(input int c, input color_idx_t bg,
                                            input color_idx_t sp, input logic prio);
        color_idx_t b;
        color_idx_t s;
        pal_entry_t e;
        b = (!show_bg || (c < 8 && !show_bg_left)) ? 4'd0 : bg;
        s = (!show_sp || (c < 8 && !show_sp_left)) ? 4'd0 : sp;
        if (s[1:0] != 2'd0 && (b[1:0] == 2'd0 || !prio)) begin
            e = pal_shadow[{1'b1, s}];
        end else begin
            e = pal_shadow[{1'b0, b}];
        end
        if (greyscale) begin
            e = e & 8'h30;
        end
        return e[5:0];
    endfunction

    task automatic drive_line(input int row, input logic random_mode, input color_idx_t bg_c,
                              input color_idx_t sp_c, input logic zero_c);
        logic [31:0] r;
        color_idx_t  b;
        color_idx_t  s;
        logic        p;
        wait_dot(row - 1, 340);
        for (int c = 0; c < 256; c++) begin
            r = $random(seed);
            b = random_mode ? r[3:0] : bg_c;
            s = random_mode ? r[7:4] : sp_c;
            p = random_mode & r[8];
            @(posedge clk);
            bg_idx  <= b;
            sp_idx  <= s;
            sp_prio <= p;
            sp_zero <= zero_c;
            exp_line[c] = expect_pixel(c, b, s, p);
        end
        @(posedge clk);
        bg_idx  <= '0;
        sp_idx  <= '0;
        sp_prio <= 1'b0;
        sp_zero <= 1'b0;
    endtask

    // display line holds the row during the following row
    task automatic read_line(input string name, input int row);
        wait_dot(row + 1, 0);
        for (int i = 0; i < 256; i++) begin
            @(posedge clk);
            disp_idx <= i[7:0];
            @(negedge clk);
            check_value(name, $sformatf("index %0d", i), int'(exp_line[i]), int'(disp_pixel));
        end
        finish_test(name);
    endtask

    // a single opaque overlap dot with sp_zero set
    task automatic overlap_at(input string name, input int row, input int col, input logic hit);
        wait_dot(row, col - 1);
        @(posedge clk);
        bg_idx  <= 4'h1;
        sp_idx  <= 4'h1;
        sp_zero <= 1'b1;
        @(posedge clk);
        bg_idx  <= '0;
        sp_idx  <= '0;
        sp_zero <= 1'b0;
        @(negedge clk);
        check_value(name, $sformatf("hit after col %0d", col), int'(hit), int'(sp_zero_hit));
    endtask

    task automatic frame_flags(input string name, input logic nmi_on);
        int low_dots;
        int first_low;
        int rise_col;
        low_dots  = 0;
        first_low = -1;
        rise_col  = -1;
        wait_dot(240, 340);
        // first dots of the post-render line
        for (int c = 0; c < 8; c++) begin
            @(negedge clk);
            if (!nmi_n) begin
                low_dots++;
                if (first_low < 0) begin
                    first_low = c;
                end
            end
            if (vblank && rise_col < 0) begin
                rise_col = c;
            end
        end
        check_value(name, "vblank seen from col", 1, rise_col);
        check_value(name, "nmi low dots", nmi_on ? 3 : 0, low_dots);
        check_value(name, "nmi first low col", nmi_on ? 0 : -1, first_low);
        wait_dot(0, 0);
        check_value(name, "vblank during row 0 col 0", 1, int'(vblank));
        wait_dot(0, 1);
        check_value(name, "vblank after row 0 col 0", 0, int'(vblank));
        check_value(name, "sp_zero_hit after row 0 col 0", 0, int'(sp_zero_hit));
        finish_test(name);
    endtask

    initial begin
        logic [31:0] r;
        seed         = 24;
        rst_n        = 1'b0;
        dot_en       = 1'b1;
        bg_idx       = '0;
        sp_idx       = '0;
        sp_prio      = 1'b0;
        sp_zero      = 1'b0;
        show_bg      = 1'b0;
        show_sp      = 1'b0;
        show_bg_left = 1'b0;
        show_sp_left = 1'b0;
        greyscale    = 1'b0;
        nmi_enable   = 1'b0;
        pal_we       = 1'b0;
        pal_addr     = '0;
        pal_data     = '0;
        disp_idx     = '0;
        tests        = 0;
        failed       = 0;
        errors       = 0;
        test_errors  = 0;
        timeouts     = 0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        // palette load during the pre-render line
        for (int k = 0; k < 32; k++) begin
            r = $random(seed);
            @(posedge clk);
            pal_we   <= 1'b1;
            pal_addr <= k[4:0];
            pal_data <= r[7:0];
            pal_shadow[k] = r[7:0];
        end
        @(posedge clk);
        pal_we       <= 1'b0;
        show_bg      <= 1'b1;
        show_sp      <= 1'b1;
        show_bg_left <= 1'b1;
        show_sp_left <= 1'b1;
        nmi_enable   <= 1'b1;

        r = $random(seed);
        const_bg = r[3:0];
        drive_line(5, 1'b0, const_bg, 4'd0, 1'b0);
        read_line("palette", 5);
        @(posedge clk);
        greyscale <= 1'b1;
        drive_line(7, 1'b0, const_bg, 4'd0, 1'b0);
        read_line("greyscale", 7);
        @(posedge clk);
        greyscale <= 1'b0;
        drive_line(10, 1'b1, '0, '0, 1'b0);
        read_line("priority", 10);
        @(posedge clk);
        show_bg_left <= 1'b0;
        show_sp_left <= 1'b0;
        drive_line(12, 1'b1, '0, '0, 1'b0);
        read_line("left_clip", 12);
        @(posedge clk);
        show_bg_left <= 1'b1;
        show_sp_left <= 1'b1;
        show_sp      <= 1'b0;
        drive_line(14, 1'b1, '0, '0, 1'b0);
        read_line("show_sp", 14);
        @(posedge clk);
        show_sp <= 1'b1;
        frame_flags("vblank_nmi", 1'b1);

        // second frame with nmi disabled
        @(posedge clk);
        nmi_enable <= 1'b0;
        drive_line(20, 1'b0, 4'h1, 4'h0, 1'b1);
        wait_dot(20, 300);
        check_value("sprite_zero", "bg only", 0, int'(sp_zero_hit));
        drive_line(22, 1'b0, 4'h0, 4'h2, 1'b1);
        wait_dot(22, 300);
        check_value("sprite_zero", "sprite only", 0, int'(sp_zero_hit));
        overlap_at("sprite_zero", 25, 300, 1'b0);
        overlap_at("sprite_zero", 30, 200, 1'b1);
        finish_test("sprite_zero");
        frame_flags("vblank_no_nmi", 1'b0);

        assert_fails = ppu_core_i.ppu_core_asserts_i.fail_count;
        $display("%0d tests, %0d failed, %0d check errors, %0d assertion failures, %0d timeouts",
                 tests, failed, errors, assert_fails, timeouts);
        if (failed == 0 && errors == 0 && assert_fails == 0 && timeouts == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== files.f ====
src/ppu_pkg.sv
src/ppu_timing_if.sv
src/dot_counter.sv
src/scan_fsm.sv
src/pixel_compositor.sv
src/line_buffers.sv
src/ppu_status.sv
src/ppu_core.sv
tb/ppu_core_asserts.sv
tb/tb_ppu_core.sv

// ==== run.sh ====
#!/bin/bash
rm -f sim.log
verilator --binary --assert --top-module tb_ppu_core -f files.f -o sim_ppu \
    || { echo "build failed"; exit 1; }
./obj_dir/sim_ppu +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
grep -q "Test FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Test OK" sim.log || { echo "no pass message in log"; exit 1; }
exit 0
